//--- include/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// instructions renamed per cycle
// lane 0 is the older one
`define RENAME_WIDTH 2

// architectural register file size
// x0 keeps tag 0 for good
`define ARCH_REG_SZ 32

// physical register file size
// tags from ARCH_REG_SZ up start out free
`define PHYS_REG_SZ 64

// slots between rename and dispatch
// must hold at least one full bundle
`define RQ_DEPTH 8

`endif

//--- design/arch_pkg.sv
`include "rename_settings.svh"

package arch_pkg;

    // architectural register number
    typedef logic [$clog2(`ARCH_REG_SZ)-1:0] reg_idx_t;

    // physical register tag
    typedef logic [$clog2(`PHYS_REG_SZ)-1:0] phys_reg_idx_t;

    // one map table slot
    // ready means the value for tag is already in the register file
    typedef struct packed {
        phys_reg_idx_t tag;
        logic          ready;
    } map_entry_t;

endpackage

//--- design/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    import arch_pkg::*;

    // coarse instruction class
    // only alu and load produce a register result
    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_branch
    } opcode_t;

    // what the rename stage hands to dispatch
    // old_tag goes back to the free list when the instruction retires
    typedef struct packed {
        opcode_t       opcode;
        map_entry_t    src1;
        map_entry_t    src2;
        phys_reg_idx_t new_tag;
        phys_reg_idx_t old_tag;
    } renamed_inst_t;

    // true for classes that write a destination register
    function automatic logic op_writes_dest(opcode_t op);
        return (op == op_alu) || (op == op_load);
    endfunction

endpackage

//--- design/free_list.sv
`include "rename_settings.svh"

module free_list (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                    [`RENAME_WIDTH-1:0] alloc_need,
    input  logic                                        alloc_en,
    input  logic                    [`RENAME_WIDTH-1:0] release_valid,
    input  arch_pkg::phys_reg_idx_t [`RENAME_WIDTH-1:0] release_tag,
    output arch_pkg::phys_reg_idx_t [`RENAME_WIDTH-1:0] alloc_tag,
    output logic                    [$clog2(`PHYS_REG_SZ):0] free_count
);
    import arch_pkg::*;

    localparam int PTR_W    = $clog2(`PHYS_REG_SZ);
    localparam int CNT_W    = PTR_W + 1;
    localparam int INIT_CNT = `PHYS_REG_SZ - `ARCH_REG_SZ;

    // tag ring, one slot per physical register so it never overflows
    phys_reg_idx_t    mem [`PHYS_REG_SZ];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    // per lane read and write positions
    logic [PTR_W-1:0] rd_ptr [`RENAME_WIDTH];
    logic [PTR_W-1:0] wr_ptr [`RENAME_WIDTH];
    logic [PTR_W-1:0] n_alloc;
    logic [PTR_W-1:0] n_rel;

    // needing lanes take consecutive head slots in lane order
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            rd_ptr[i]    = head + n_alloc;
            alloc_tag[i] = mem[rd_ptr[i]];
            if (alloc_need[i]) begin
                n_alloc = n_alloc + PTR_W'(1);
            end
        end
    end

    // released tags packed at the tail, lane 0 first
    always_comb begin
        n_rel = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            wr_ptr[i] = tail + n_rel;
            if (release_valid[i]) begin
                n_rel = n_rel + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= PTR_W'(INIT_CNT);
            count <= CNT_W'(INIT_CNT);
            // everything above the identity mapping starts free
            for (int i = 0; i < INIT_CNT; i++) begin
                mem[i] <= phys_reg_idx_t'(`ARCH_REG_SZ + i);
            end
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (release_valid[i]) begin
                    mem[wr_ptr[i]] <= release_tag[i];
                end
            end
            // accept logic only raises alloc_en when enough tags are here
            if (alloc_en) begin
                head <= head + n_alloc;
            end
            tail  <= tail + n_rel;
            count <= count + CNT_W'(n_rel) - (alloc_en ? CNT_W'(n_alloc) : '0);
        end
    end

    assign free_count = count;

endmodule

//--- design/map_table.sv
`include "rename_settings.svh"

module map_table (
    input  logic                                        clock,
    input  logic                                        reset,
    input  arch_pkg::reg_idx_t      [`RENAME_WIDTH-1:0] src1_idx,
    input  arch_pkg::reg_idx_t      [`RENAME_WIDTH-1:0] src2_idx,
    input  arch_pkg::reg_idx_t      [`RENAME_WIDTH-1:0] dest_idx,
    input  logic                    [`RENAME_WIDTH-1:0] writes_dest,
    input  arch_pkg::phys_reg_idx_t [`RENAME_WIDTH-1:0] new_tag,
    input  logic                                        rename_en,
    input  logic                    [`RENAME_WIDTH-1:0] cdb_valid,
    input  arch_pkg::reg_idx_t      [`RENAME_WIDTH-1:0] cdb_arch,
    input  arch_pkg::phys_reg_idx_t [`RENAME_WIDTH-1:0] cdb_phys,
    output arch_pkg::map_entry_t    [`RENAME_WIDTH-1:0] src1_entry,
    output arch_pkg::map_entry_t    [`RENAME_WIDTH-1:0] src2_entry,
    output arch_pkg::phys_reg_idx_t [`RENAME_WIDTH-1:0] old_tag
);
    import arch_pkg::*;

    // committed map, one slot per architectural register
    map_entry_t entries      [`ARCH_REG_SZ];
    // map after this cycle's completions
    map_entry_t cdb_entries  [`ARCH_REG_SZ];
    // map after completions and the renamed bundle
    map_entry_t work_entries [`ARCH_REG_SZ];

    // completion broadcast
    // only counts if the arch reg still points at that tag
    // a stale tag leaves the bit as it was
    always_comb begin
        cdb_entries = entries;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (cdb_valid[i] && (cdb_entries[cdb_arch[i]].tag == cdb_phys[i])) begin
                cdb_entries[cdb_arch[i]].ready = 1'b1;
            end
        end
    end

    // lanes walked oldest first
    // so lane 1 reads whatever lane 0 just mapped
    always_comb begin
        work_entries = cdb_entries;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            src1_entry[i] = work_entries[src1_idx[i]];
            src2_entry[i] = work_entries[src2_idx[i]];
            // previous producer of dest, freed when this one retires
            old_tag[i]    = work_entries[dest_idx[i]].tag;
            if (writes_dest[i]) begin
                work_entries[dest_idx[i]].tag   = new_tag[i];
                // result pending until its broadcast
                work_entries[dest_idx[i]].ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, all values present
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                entries[i].tag   <= phys_reg_idx_t'(i);
                entries[i].ready <= 1'b1;
            end
        end else if (rename_en) begin
            entries <= work_entries;
        end else begin
            // bundle stalled, completions still land
            entries <= cdb_entries;
        end
    end

endmodule

//--- design/rename_queue.sv
`include "rename_settings.svh"

module rename_queue (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                      [`RENAME_WIDTH-1:0] enq_valid,
    input  rename_pkg::renamed_inst_t [`RENAME_WIDTH-1:0] enq_inst,
    input  logic                                          enq_en,
    output logic                                          space_ok,
    output logic                                          deq_valid,
    output rename_pkg::renamed_inst_t                     deq_inst,
    input  logic                                          deq_ready
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`RQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    renamed_inst_t    slots [`RQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] wr_ptr [`RENAME_WIDTH];
    logic [CNT_W-1:0] n_enq;
    logic             pop;

    // valid lanes go to consecutive tail slots
    // a hole in lane 0 does not leave a gap
    always_comb begin
        n_enq = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            wr_ptr[i] = tail + n_enq[PTR_W-1:0];
            if (enq_en && enq_valid[i]) begin
                n_enq = n_enq + CNT_W'(1);
            end
        end
    end

    // room for a whole bundle, whatever its lanes hold
    assign space_ok  = (CNT_W'(`RQ_DEPTH) - count) >= CNT_W'(`RENAME_WIDTH);
    assign deq_valid = (count != '0);
    assign deq_inst  = slots[head];
    assign pop       = deq_valid && deq_ready;

    // payload storage
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (enq_en && enq_valid[i]) begin
                slots[wr_ptr[i]] <= enq_inst[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(pop);
            tail  <= tail + n_enq[PTR_W-1:0];
            count <= count + n_enq - CNT_W'(pop);
        end
    end

endmodule

//--- design/rename_unit.sv
`include "rename_settings.svh"

module rename_unit (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                      [`RENAME_WIDTH-1:0] decode_valid,
    input  rename_pkg::opcode_t       [`RENAME_WIDTH-1:0] decode_opcode,
    input  arch_pkg::reg_idx_t        [`RENAME_WIDTH-1:0] decode_src1,
    input  arch_pkg::reg_idx_t        [`RENAME_WIDTH-1:0] decode_src2,
    input  arch_pkg::reg_idx_t        [`RENAME_WIDTH-1:0] decode_dest,
    output logic                                          decode_ready,
    input  logic                      [`RENAME_WIDTH-1:0] cdb_valid,
    input  arch_pkg::reg_idx_t        [`RENAME_WIDTH-1:0] cdb_arch,
    input  arch_pkg::phys_reg_idx_t   [`RENAME_WIDTH-1:0] cdb_phys,
    input  logic                      [`RENAME_WIDTH-1:0] retire_valid,
    input  arch_pkg::phys_reg_idx_t   [`RENAME_WIDTH-1:0] retire_phys,
    output logic                                          dispatch_valid,
    output rename_pkg::renamed_inst_t                     dispatch_inst,
    input  logic                                          dispatch_ready
);
    import arch_pkg::*;
    import rename_pkg::*;

    localparam int CNT_W = $clog2(`PHYS_REG_SZ) + 1;

    logic [`RENAME_WIDTH-1:0]           lane_writes;
    logic [CNT_W-1:0]                   n_need;
    logic [CNT_W-1:0]                   free_count;
    logic                               space_ok;
    logic                               accept;
    phys_reg_idx_t [`RENAME_WIDTH-1:0]  alloc_tag;
    phys_reg_idx_t [`RENAME_WIDTH-1:0]  old_tag;
    map_entry_t    [`RENAME_WIDTH-1:0]  src1_entry;
    map_entry_t    [`RENAME_WIDTH-1:0]  src2_entry;
    renamed_inst_t [`RENAME_WIDTH-1:0]  enq_inst;

    // lane needs a tag
    // x0 writes are dropped, so they take none
    always_comb begin
        n_need = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            lane_writes[i] = decode_valid[i] && op_writes_dest(decode_opcode[i])
                             && (decode_dest[i] != '0);
            if (lane_writes[i]) begin
                n_need = n_need + CNT_W'(1);
            end
        end
    end

    // whole bundle or nothing
    assign decode_ready = space_ok && (free_count >= n_need);
    assign accept       = (|decode_valid) && decode_ready;

    // tags only meaningful for lanes that write
    // zero keeps retire from freeing a bogus tag
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            enq_inst[i].opcode  = decode_opcode[i];
            enq_inst[i].src1    = src1_entry[i];
            enq_inst[i].src2    = src2_entry[i];
            enq_inst[i].new_tag = lane_writes[i] ? alloc_tag[i] : '0;
            enq_inst[i].old_tag = lane_writes[i] ? old_tag[i] : '0;
        end
    end

    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_need    (lane_writes),
        .alloc_en      (accept),
        .release_valid (retire_valid),
        .release_tag   (retire_phys),
        .alloc_tag     (alloc_tag),
        .free_count    (free_count)
    );

    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .src1_idx    (decode_src1),
        .src2_idx    (decode_src2),
        .dest_idx    (decode_dest),
        .writes_dest (lane_writes),
        .new_tag     (alloc_tag),
        .rename_en   (accept),
        .cdb_valid   (cdb_valid),
        .cdb_arch    (cdb_arch),
        .cdb_phys    (cdb_phys),
        .src1_entry  (src1_entry),
        .src2_entry  (src2_entry),
        .old_tag     (old_tag)
    );

    rename_queue u_rename_queue (
        .clock     (clock),
        .reset     (reset),
        .enq_valid (decode_valid),
        .enq_inst  (enq_inst),
        .enq_en    (accept),
        .space_ok  (space_ok),
        .deq_valid (dispatch_valid),
        .deq_inst  (dispatch_inst),
        .deq_ready (dispatch_ready)
    );

endmodule

//--- dv/rename_tb.sv
`include "rename_settings.svh"

module rename_tb;
    import arch_pkg::*;
    import rename_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int NUM_ROWS       = 48;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * (`RQ_DEPTH + 4);

    // one cycle of stimulus
    // lane 0 is the older instruction
    typedef struct {
        logic          [`RENAME_WIDTH-1:0] valid;
        opcode_t       [`RENAME_WIDTH-1:0] op;
        reg_idx_t      [`RENAME_WIDTH-1:0] src1;
        reg_idx_t      [`RENAME_WIDTH-1:0] src2;
        reg_idx_t      [`RENAME_WIDTH-1:0] dest;
        logic          [`RENAME_WIDTH-1:0] cdb_v;
        reg_idx_t      [`RENAME_WIDTH-1:0] cdb_a;
        phys_reg_idx_t [`RENAME_WIDTH-1:0] cdb_p;
        int                                n_retire;
        logic                              drdy;
    } row_t;

    logic                              clock;
    logic                              reset;
    logic          [`RENAME_WIDTH-1:0] decode_valid;
    opcode_t       [`RENAME_WIDTH-1:0] decode_opcode;
    reg_idx_t      [`RENAME_WIDTH-1:0] decode_src1;
    reg_idx_t      [`RENAME_WIDTH-1:0] decode_src2;
    reg_idx_t      [`RENAME_WIDTH-1:0] decode_dest;
    logic                              decode_ready;
    logic          [`RENAME_WIDTH-1:0] cdb_valid;
    reg_idx_t      [`RENAME_WIDTH-1:0] cdb_arch;
    phys_reg_idx_t [`RENAME_WIDTH-1:0] cdb_phys;
    logic          [`RENAME_WIDTH-1:0] retire_valid;
    phys_reg_idx_t [`RENAME_WIDTH-1:0] retire_phys;
    logic                              dispatch_valid;
    renamed_inst_t                     dispatch_inst;
    logic                              dispatch_ready;

    // stimulus table and reference model state
    row_t                              rows [NUM_ROWS];
    row_t                              idle_row;
    map_entry_t                        model_map [`ARCH_REG_SZ];
    phys_reg_idx_t                     free_q [$];
    phys_reg_idx_t                     retire_pool [$];
    renamed_inst_t                     exp_q [$];
    logic          [`RENAME_WIDTH-1:0] ret_v;
    phys_reg_idx_t [`RENAME_WIDTH-1:0] ret_p;
    int                                alloc_total;
    int                                cycle_count = 0;
    bit                                saw_queue_stall;
    bit                                saw_tag_stall;
    bit                                saw_tag_resume;

    rename_unit u_rename_unit (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_tag(string name, phys_reg_idx_t exp, phys_reg_idx_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_entry(string name, map_entry_t exp, map_entry_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected tag %0d ready %0b got tag %0d ready %0b",
                     $time, name, exp.tag, exp.ready, act.tag, act.ready);
            abort_run();
        end
    endtask

    task automatic check_opcode(string name, opcode_t exp, opcode_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %s got %s", $time, name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0b got %0b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic put_lane(int r, int l, opcode_t op, int s1, int s2, int d);
        rows[r].valid[l] = 1'b1;
        rows[r].op[l]    = op;
        rows[r].src1[l]  = reg_idx_t'(s1);
        rows[r].src2[l]  = reg_idx_t'(s2);
        rows[r].dest[l]  = reg_idx_t'(d);
    endtask

    task automatic put_cdb(int r, int l, int a, int p);
        rows[r].cdb_v[l] = 1'b1;
        rows[r].cdb_a[l] = reg_idx_t'(a);
        rows[r].cdb_p[l] = phys_reg_idx_t'(p);
    endtask

    task automatic build_table();
        // filler rows with two tag-hungry lanes each
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r].cdb_v    = '0;
            rows[r].cdb_a    = '0;
            rows[r].cdb_p    = '0;
            rows[r].drdy     = 1'b1;
            // last rows hand old tags back
            rows[r].n_retire = (r >= NUM_ROWS - 4) ? 2 : 0;
            for (int l = 0; l < `RENAME_WIDTH; l++) begin
                put_lane(r, l, opcode_t'($urandom % 2), $urandom % 32, $urandom % 32,
                         $urandom % 31 + 1);
            end
        end
        // dispatch stalled long enough to fill the queue
        for (int r = 6; r <= 10; r++) begin
            rows[r].drdy = 1'b0;
        end
        // fresh map with identity sources
        put_lane(0, 0, op_alu, 2, 3, 1);
        put_lane(0, 1, op_alu, 5, 6, 4);
        // lane 1 reads x7 just renamed by lane 0
        put_lane(1, 0, op_alu, 1, 0, 7);
        put_lane(1, 1, op_alu, 7, 4, 8);
        // store and x0 write take no tag
        put_lane(2, 0, op_store, 7, 8, 5);
        put_lane(2, 1, op_alu, 1, 2, 0);
        // x1 completes with tag 32
        // x4 broadcast carries its replaced tag 4
        // branch with a real dest field takes no tag
        put_lane(3, 0, op_alu, 1, 2, 9);
        put_lane(3, 1, op_branch, 4, 9, 6);
        put_cdb(3, 0, 1, 32);
        put_cdb(3, 1, 4, 4);
        put_lane(4, 0, op_alu, 4, 1, 4);
        put_lane(4, 1, op_alu, 4, 3, 10);
        // tag 33 is stale by now
        // 38 still belongs to x10
        // lone lane 1 goes to the next queue slot and the head tag
        put_lane(5, 1, op_load, 4, 10, 11);
        rows[5].valid[0] = 1'b0;
        put_cdb(5, 0, 4, 33);
        put_cdb(5, 1, 10, 38);
        // drain cycles
        idle_row          = rows[0];
        idle_row.valid    = '0;
        idle_row.cdb_v    = '0;
        idle_row.n_retire = 0;
        idle_row.drdy     = 1'b1;
    endtask

    task automatic drive_row(row_t row);
        ret_v = '0;
        ret_p = '0;
        // oldest replaced tags retire first
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (i < row.n_retire && retire_pool.size() != 0) begin
                ret_v[i] = 1'b1;
                ret_p[i] = retire_pool.pop_front();
            end
        end
        decode_valid   <= row.valid;
        decode_opcode  <= row.op;
        decode_src1    <= row.src1;
        decode_src2    <= row.src2;
        decode_dest    <= row.dest;
        cdb_valid      <= row.cdb_v;
        cdb_arch       <= row.cdb_a;
        cdb_phys       <= row.cdb_p;
        retire_valid   <= ret_v;
        retire_phys    <= ret_p;
        dispatch_ready <= row.drdy;
    endtask

    // compare this cycle's outputs and advance the model one edge
    task automatic model_cycle(row_t row);
        int            need;
        int            space;
        logic          exp_ready;
        logic          accept;
        logic          writes;
        renamed_inst_t inst;
        need  = 0;
        space = `RQ_DEPTH - exp_q.size();
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (row.valid[i] && (row.op[i] == op_alu || row.op[i] == op_load)
                && row.dest[i] != '0) begin
                need++;
            end
        end
        exp_ready = (space >= `RENAME_WIDTH) && (free_q.size() >= need);
        accept    = (row.valid != '0) && exp_ready;
        check_flag("decode_ready", exp_ready, decode_ready);
        check_flag("dispatch_valid", exp_q.size() != 0, dispatch_valid);
        if (exp_q.size() != 0) begin
            check_opcode("dispatch_inst.opcode", exp_q[0].opcode, dispatch_inst.opcode);
            check_entry("dispatch_inst.src1", exp_q[0].src1, dispatch_inst.src1);
            check_entry("dispatch_inst.src2", exp_q[0].src2, dispatch_inst.src2);
            check_tag("dispatch_inst.new_tag", exp_q[0].new_tag, dispatch_inst.new_tag);
            check_tag("dispatch_inst.old_tag", exp_q[0].old_tag, dispatch_inst.old_tag);
            if (row.drdy) begin
                exp_q.delete(0);
            end
        end
        if (row.valid != '0 && !exp_ready) begin
            if (space < `RENAME_WIDTH) begin
                saw_queue_stall = 1'b1;
            end else begin
                saw_tag_stall = 1'b1;
            end
        end
        if (accept && need > 0 && saw_tag_stall) begin
            saw_tag_resume = 1'b1;
        end
        // completions land before the bundle reads the map
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (row.cdb_v[i] && model_map[row.cdb_a[i]].tag == row.cdb_p[i]) begin
                model_map[row.cdb_a[i]].ready = 1'b1;
            end
        end
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (accept && row.valid[i]) begin
                writes       = (row.op[i] == op_alu || row.op[i] == op_load)
                               && row.dest[i] != '0;
                inst.opcode  = row.op[i];
                inst.src1    = model_map[row.src1[i]];
                inst.src2    = model_map[row.src2[i]];
                inst.new_tag = '0;
                inst.old_tag = '0;
                if (writes) begin
                    inst.new_tag = free_q.pop_front();
                    inst.old_tag = model_map[row.dest[i]].tag;
                    model_map[row.dest[i]] = '{tag: inst.new_tag, ready: 1'b0};
                    retire_pool.push_back(inst.old_tag);
                    alloc_total++;
                end
                exp_q.push_back(inst);
            end
        end
        // released tags usable from the next cycle on
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (ret_v[i]) begin
                free_q.push_back(ret_p[i]);
            end
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, dispatch stalled with %0d instructions left",
                     cycle_count, exp_q.size());
            abort_run();
        end
    end

    initial begin
        void'($urandom(32'h8595));
        reset          = 1'b1;
        decode_valid   = '0;
        decode_src1    = '0;
        decode_src2    = '0;
        decode_dest    = '0;
        cdb_valid      = '0;
        cdb_arch       = '0;
        cdb_phys       = '0;
        retire_valid   = '0;
        retire_phys    = '0;
        dispatch_ready = 1'b0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            decode_opcode[l] = op_alu;
        end
        build_table();
        // model after reset has an identity map and tags 32 up free
        for (int a = 0; a < `ARCH_REG_SZ; a++) begin
            model_map[a] = '{tag: phys_reg_idx_t'(a), ready: 1'b1};
        end
        for (int p = `ARCH_REG_SZ; p < `PHYS_REG_SZ; p++) begin
            free_q.push_back(phys_reg_idx_t'(p));
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clock);
            drive_row(rows[r]);
            @(negedge clock);
            model_cycle(rows[r]);
        end
        while (exp_q.size() != 0) begin
            @(posedge clock);
            drive_row(idle_row);
            @(negedge clock);
            model_cycle(idle_row);
        end
        if (!saw_queue_stall) begin
            $display("no bundle was ever held back by a full rename queue");
            abort_run();
        end else if (!saw_tag_stall || !saw_tag_resume) begin
            $display("free list never ran dry and refilled during the run");
            abort_run();
        end else if (alloc_total <= `PHYS_REG_SZ - `ARCH_REG_SZ) begin
            $display("no retired tag was ever allocated again");
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+include
design/arch_pkg.sv
design/rename_pkg.sv
design/free_list.sv
design/map_table.sv
design/rename_queue.sv
design/rename_unit.sv
dv/rename_tb.sv

//--- Makefile
all: run

obj_dir/Vrename_tb: sources.f $(wildcard include/*.svh design/*.sv dv/*.sv)
	verilator --binary --timing -f sources.f --top-module rename_tb

run: obj_dir/Vrename_tb
	-obj_dir/Vrename_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
